// File: src/reorderPkg.sv
/*
 * Reorder buffer shared definitions
 * Issue-number type and the execution-unit report channels
 */

package reorderPkg;

	//////////////////////////////////////////////////////////////////////
	// Issue numbers
	//////////////////////////////////////////////////////////////////////

	localparam int issueWidth = 8;	// Bits per issue number

	typedef logic [issueWidth-1:0] issueNumber;

	//////////////////////////////////////////////////////////////////////
	// Execution-unit report channels
	//////////////////////////////////////////////////////////////////////

	localparam int unitCount = 3;	// Units that report completion

	// Channel names, also used as array indices
	typedef enum logic [1:0] {
		ldSt1,	// First load/store unit
		ldSt2,	// Second load/store unit
		math	// Math unit
	} unitId;

endpackage

// File: src/ringPointerIf.sv
/*
 * Ring pointer link
 * Strobes from the entry table, pointers and fill state back from control
 */

`timescale 1ns/1ps

interface ringPointerIf #(
	parameter int entryCount = 16
);

	localparam int addrWidth = (entryCount > 1) ? $clog2(entryCount) : 1;

	logic write;	// Store accepted this cycle
	logic read;	// Head popped this cycle
	logic [addrWidth-1:0] writeAddr;	// Tail slot
	logic [addrWidth-1:0] readAddr;	// Head slot
	logic full;
	logic empty;

	modport tableSide (output write, read, input writeAddr, readAddr, full, empty);
	modport control (input write, read, output writeAddr, readAddr, full, empty);

endinterface

// File: src/unitReportIf.sv
/*
 * Unit report link
 * Held completion reports toward the table, acceptance pulses back
 */

`timescale 1ns/1ps

interface unitReportIf;

	//////////////////////////////////////////////////////////////////////
	// Capture side
	//////////////////////////////////////////////////////////////////////

	logic pending [reorderPkg::unitCount];	// Report held per unit
	reorderPkg::issueNumber number [reorderPkg::unitCount];	// Held issue number

	//////////////////////////////////////////////////////////////////////
	// Table side
	//////////////////////////////////////////////////////////////////////

	// One-cycle pulse when the held number hit a live entry
	logic accepted [reorderPkg::unitCount];

	modport capture (output pending, number, input accepted);
	modport tableSide (input pending, number, output accepted);

endinterface

// File: src/ringBufferControl.sv
/*
 * Ring buffer control
 * Head and tail pointers plus occupancy count for the entry ring
 * Full and empty are decoded from the count
 */

`timescale 1ns/1ps

module ringBufferControl #(
	parameter int entryCount = 16
)(
	input logic clock,
	input logic reset,
	ringPointerIf.control ring
);

	localparam int addrWidth = (entryCount > 1) ? $clog2(entryCount) : 1;
	localparam int countWidth = $clog2(entryCount + 1);

	logic [countWidth-1:0] count;	// Entries in flight

	//////////////////////////////////////////////////////////////////////
	// Pointers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			ring.writeAddr <= '0;
			ring.readAddr <= '0;
		end else begin
			if (ring.write) begin
				if (ring.writeAddr == addrWidth'(entryCount - 1))
					ring.writeAddr <= '0;	// Wrap
				else
					ring.writeAddr <= ring.writeAddr + 1'b1;
			end
			if (ring.read) begin
				if (ring.readAddr == addrWidth'(entryCount - 1))
					ring.readAddr <= '0;
				else
					ring.readAddr <= ring.readAddr + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Occupancy
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset)
			count <= '0;
		else if (ring.write && !ring.read)
			count <= count + 1'b1;
		else if (ring.read && !ring.write)
			count <= count - 1'b1;
		// Both strobes together leave the count alone
	end

	assign ring.full = (count == countWidth'(entryCount));
	assign ring.empty = (count == '0);

endmodule

// File: src/completionCapture.sv
/*
 * Completion capture
 * One hold register per execution unit, kept until the table accepts it
 */

`timescale 1ns/1ps

module completionCapture (
	input logic clock,
	input logic reset,
	input logic reportRequest [reorderPkg::unitCount],
	input reorderPkg::issueNumber reportNumber [reorderPkg::unitCount],
	unitReportIf.capture report
);

	//////////////////////////////////////////////////////////////////////
	// Pending flags
	//////////////////////////////////////////////////////////////////////

	// Acceptance wins over a new request, though units wait for it anyway
	always_ff @(posedge clock) begin
		for (int u = 0; u < reorderPkg::unitCount; u++) begin
			if (reset)
				report.pending[u] <= 1'b0;
			else if (report.accepted[u])
				report.pending[u] <= 1'b0;	// Drop once matched
			else if (reportRequest[u])
				report.pending[u] <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Held numbers
	//////////////////////////////////////////////////////////////////////

	// Loaded with the request, only looked at while pending
	always_ff @(posedge clock) begin
		for (int u = 0; u < reorderPkg::unitCount; u++) begin
			if (reportRequest[u] && !report.accepted[u])
				report.number[u] <= reportNumber[u];
		end
	end

endmodule

// File: src/reorderTable.sv
/*
 * Reorder table
 * Entry storage in issue order, matching of held completion reports
 * and presentation of the head entry for commit
 */

`timescale 1ns/1ps

module reorderTable #(
	parameter int entryCount = 16
)(
	input logic clock,
	input logic reset,
	input logic store,
	input reorderPkg::issueNumber issueNumber,
	input logic commitGrant,
	ringPointerIf.tableSide ring,
	unitReportIf.tableSide report,
	output logic commitRequest,
	output reorderPkg::issueNumber commitNumber
);

	logic valid [entryCount];	// Slot holds a live entry
	logic done [entryCount];	// Completion seen for slot
	reorderPkg::issueNumber number [entryCount];

	logic [entryCount-1:0] setDone;	// Slots hit by a report this cycle

	//////////////////////////////////////////////////////////////////////
	// Ring strobes
	//////////////////////////////////////////////////////////////////////

	assign ring.write = store && !ring.full;	// Store while full is dropped
	assign ring.read = commitRequest && commitGrant;

	//////////////////////////////////////////////////////////////////////
	// Report matching
	//////////////////////////////////////////////////////////////////////

	// Issue numbers are unique in flight, so at most one slot hits per unit
	always_comb begin
		setDone = '0;
		for (int u = 0; u < reorderPkg::unitCount; u++) begin
			report.accepted[u] = 1'b0;
			for (int i = 0; i < entryCount; i++) begin
				if (report.pending[u] && valid[i] && !done[i] &&
						number[i] == report.number[u]) begin
					report.accepted[u] = 1'b1;
					setDone[i] = 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Entry state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < entryCount; i++) begin
				valid[i] <= 1'b0;
				done[i] <= 1'b0;
			end
		end else begin
			for (int i = 0; i < entryCount; i++) begin
				if (setDone[i])
					done[i] <= 1'b1;
			end
			// Popped head, never the slot a report hits
			if (ring.read) begin
				valid[ring.readAddr] <= 1'b0;
				done[ring.readAddr] <= 1'b0;
			end
			// New tail, cannot collide with the head since full blocks it
			if (ring.write) begin
				valid[ring.writeAddr] <= 1'b1;
				done[ring.writeAddr] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (ring.write)
			number[ring.writeAddr] <= issueNumber;
	end

	//////////////////////////////////////////////////////////////////////
	// Commit presentation
	//////////////////////////////////////////////////////////////////////

	// Head waits here until granted
	assign commitRequest = valid[ring.readAddr] && done[ring.readAddr];
	assign commitNumber = number[ring.readAddr];

endmodule

// File: src/scalarReorderBuffer.sv
/*
 * Scalar-unit reorder buffer
 * Records issue numbers in order, collects completion reports from two
 * load/store units and the math unit, commits to the hazard unit in order
 */

`timescale 1ns/1ps

module scalarReorderBuffer #(
	parameter int entryCount = 16
)(
	input logic clock,
	input logic reset,
	input logic store,	// Record a new issue number
	input reorderPkg::issueNumber issueNumber,
	input logic reportRequest [reorderPkg::unitCount],	// Completion strobes
	input reorderPkg::issueNumber reportNumber [reorderPkg::unitCount],
	input logic commitGrant,	// Hazard unit takes the head
	output logic commitRequest,
	output reorderPkg::issueNumber commitNumber,
	output logic unitAccepted [reorderPkg::unitCount],	// Report taken, unit may go on
	output logic full,
	output logic empty
);

	ringPointerIf #(.entryCount(entryCount)) ring ();
	unitReportIf report ();

	//////////////////////////////////////////////////////////////////////
	// Report capture
	//////////////////////////////////////////////////////////////////////

	completionCapture capture (
		.clock         (clock),
		.reset         (reset),
		.reportRequest (reportRequest),
		.reportNumber  (reportNumber),
		.report        (report.capture)
	);

	//////////////////////////////////////////////////////////////////////
	// Ring pointers
	//////////////////////////////////////////////////////////////////////

	ringBufferControl #(.entryCount(entryCount)) control (
		.clock (clock),
		.reset (reset),
		.ring  (ring.control)
	);

	//////////////////////////////////////////////////////////////////////
	// Entry table
	//////////////////////////////////////////////////////////////////////

	reorderTable #(.entryCount(entryCount)) entries (
		.clock         (clock),
		.reset         (reset),
		.store         (store),
		.issueNumber   (issueNumber),
		.commitGrant   (commitGrant),
		.ring          (ring.tableSide),
		.report        (report.tableSide),
		.commitRequest (commitRequest),
		.commitNumber  (commitNumber)
	);

	// Acceptance back to each unit
	assign unitAccepted[reorderPkg::ldSt1] = report.accepted[reorderPkg::ldSt1];
	assign unitAccepted[reorderPkg::ldSt2] = report.accepted[reorderPkg::ldSt2];
	assign unitAccepted[reorderPkg::math] = report.accepted[reorderPkg::math];

	assign full = ring.full;
	assign empty = ring.empty;

endmodule

// File: bench/reorderBench.sv
/*
 * Reorder buffer testbench
 * Directed tests against a reference queue of stored issue numbers
 */

`timescale 1ns/1ps

module reorderBench;

	localparam int entryCount = 8;	// Small ring so full comes quickly
	localparam int waitLimit = 40;	// Cycles before a wait gives up

	logic clock;
	logic reset;
	logic store;
	reorderPkg::issueNumber issueIn;
	logic reportRequest [reorderPkg::unitCount];
	reorderPkg::issueNumber reportNumber [reorderPkg::unitCount];
	logic commitGrant;
	logic commitRequest;
	reorderPkg::issueNumber commitNumber;
	logic unitAccepted [reorderPkg::unitCount];
	logic full;
	logic empty;

	reorderPkg::issueNumber expected [$];	// Reference queue, head first
	logic [31:0] lfsrState = 32'h5dda_88a6;

	scalarReorderBuffer #(.entryCount(entryCount)) dut (
		.clock         (clock),
		.reset         (reset),
		.store         (store),
		.issueNumber   (issueIn),
		.reportRequest (reportRequest),
		.reportNumber  (reportNumber),
		.commitGrant   (commitGrant),
		.commitRequest (commitRequest),
		.commitNumber  (commitNumber),
		.unitAccepted  (unitAccepted),
		.full          (full),
		.empty         (empty)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = {lfsrState[30:0],
				lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
			bits = {bits[30:0], lfsrState[0]};
		end
		return bits;
	endfunction

	function automatic bit inFlight(input reorderPkg::issueNumber n);
		foreach (expected[i])
			if (expected[i] == n)
				return 1'b1;
		return 1'b0;
	endfunction

	// Issue numbers stay unique among live entries
	task automatic pickNumber(output reorderPkg::issueNumber n);
		logic [31:0] bits;
		do begin
			bits = takeBits(8);
			n = bits[7:0];
		end while (inFlight(n));
	endtask

	task automatic timeoutFail(input string what);
		$display("Timeout while waiting for %s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on timeout");
	endtask

	task automatic checkIssueNumber(input string testName, input reorderPkg::issueNumber want,
			input reorderPkg::issueNumber got);
		if (want !== got) begin
			$display("CHECK FAILED %s expected %h actual %h", testName, want, got);
			$display("*** TEST FAILED ***");
			$fatal(1, "simulation stopped on mismatch");
		end
	endtask

	task automatic checkFlag(input string testName, input logic want, input logic got);
		if (want !== got) begin
			$display("CHECK FAILED %s expected %b actual %b", testName, want, got);
			$display("*** TEST FAILED ***");
			$fatal(1, "simulation stopped on mismatch");
		end
	endtask

	// All tasks start and end on a falling edge
	task automatic storeEntry(input string testName, input reorderPkg::issueNumber n);
		checkFlag(testName, expected.size() == entryCount, full);
		checkFlag(testName, expected.size() == 0, empty);
		store = 1'b1;
		issueIn = n;
		@(negedge clock);
		store = 1'b0;
		if (expected.size() < entryCount)
			expected.push_back(n);	// Dropped when full
	endtask

	task automatic reportUnits(input string testName, input logic active [reorderPkg::unitCount],
			input reorderPkg::issueNumber numbers [reorderPkg::unitCount]);
		logic seen [reorderPkg::unitCount];
		int waited;
		bit allSeen;
		for (int u = 0; u < reorderPkg::unitCount; u++) begin
			reportRequest[u] = active[u];
			reportNumber[u] = numbers[u];
			seen[u] = !active[u];
		end
		@(negedge clock);
		for (int u = 0; u < reorderPkg::unitCount; u++)
			reportRequest[u] = 1'b0;
		waited = 0;
		allSeen = 1'b0;
		while (!allSeen) begin
			allSeen = 1'b1;
			for (int u = 0; u < reorderPkg::unitCount; u++) begin
				if (unitAccepted[u])
					seen[u] = 1'b1;
				allSeen = allSeen && seen[u];
			end
			if (!allSeen) begin
				if (waited == waitLimit)
					timeoutFail("unitAccepted after a completion report");
				@(negedge clock);
				waited++;
			end
		end
		@(negedge clock);	// Done flag is set by now
		for (int u = 0; u < reorderPkg::unitCount; u++)
			checkFlag(testName, 1'b0, unitAccepted[u]);
	endtask

	task automatic reportOne(input string testName, input int unit,
			input reorderPkg::issueNumber n);
		logic active [reorderPkg::unitCount];
		reorderPkg::issueNumber numbers [reorderPkg::unitCount];
		for (int u = 0; u < reorderPkg::unitCount; u++) begin
			active[u] = (u == unit % reorderPkg::unitCount);
			numbers[u] = n;
		end
		reportUnits(testName, active, numbers);
	endtask

	task automatic commitHead(input string testName);
		reorderPkg::issueNumber want;
		int waited;
		waited = 0;
		while (!commitRequest) begin
			if (waited == waitLimit)
				timeoutFail("commitRequest");
			@(negedge clock);
			waited++;
		end
		want = expected.pop_front();
		checkIssueNumber(testName, want, commitNumber);
		commitGrant = 1'b1;
		@(negedge clock);
		commitGrant = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic testResetState();
		checkFlag("resetState", 1'b1, empty);
		checkFlag("resetState", 1'b0, full);
		checkFlag("resetState", 1'b0, commitRequest);
		for (int u = 0; u < reorderPkg::unitCount; u++)
			checkFlag("resetState", 1'b0, unitAccepted[u]);
	endtask

	// Stores count numbers, reports them in the given order, commits all
	task automatic runBatch(input string testName, input int count, input bit shuffle,
			input int holdCycles);
		reorderPkg::issueNumber numbers [entryCount+1];
		int order [entryCount];
		logic [31:0] bits;
		int pick;
		int swap;
		bit headSeen;
		for (int i = 0; i < count; i++) begin
			pickNumber(numbers[i]);
			storeEntry(testName, numbers[i]);
			order[i] = i;
		end
		if (count == entryCount) begin
			pickNumber(numbers[entryCount]);	// Must not reach the ring
			storeEntry(testName, numbers[entryCount]);
			checkFlag(testName, 1'b1, full);
		end
		for (int i = count - 1; i > 0 && shuffle; i--) begin
			bits = takeBits(3);
			pick = int'(bits % (i + 1));
			swap = order[i];
			order[i] = order[pick];
			order[pick] = swap;
		end
		headSeen = 1'b0;
		for (int i = 0; i < count; i++) begin
			reportOne(testName, i, numbers[order[i]]);
			headSeen = headSeen || (order[i] == 0);
			checkFlag(testName, headSeen, commitRequest);
		end
		repeat (holdCycles) begin	// No grant, head must hold still
			checkFlag(testName, 1'b1, commitRequest);
			checkIssueNumber(testName, expected[0], commitNumber);
			@(negedge clock);
		end
		for (int i = 0; i < count; i++)
			commitHead(testName);
		checkFlag(testName, 1'b1, empty);
	endtask

	task automatic testSimultaneous();
		logic active [reorderPkg::unitCount];
		reorderPkg::issueNumber numbers [reorderPkg::unitCount];
		for (int u = 0; u < reorderPkg::unitCount; u++) begin
			pickNumber(numbers[reorderPkg::unitCount - 1 - u]);	// Reverse of store order
			storeEntry("simultaneous", numbers[reorderPkg::unitCount - 1 - u]);
			active[u] = 1'b1;
		end
		reportUnits("simultaneous", active, numbers);
		for (int u = 0; u < reorderPkg::unitCount; u++)
			commitHead("simultaneous");
		checkFlag("simultaneous", 1'b1, empty);
	endtask

	initial begin
		store = 1'b0;
		issueIn = '0;
		commitGrant = 1'b0;
		for (int u = 0; u < reorderPkg::unitCount; u++) begin
			reportRequest[u] = 1'b0;
			reportNumber[u] = '0;
		end
		reset = 1'b1;
		repeat (3) @(negedge clock);
		reset = 1'b0;
		testResetState();
		runBatch("inOrder", 4, 1'b0, 0);
		runBatch("outOfOrder", 6, 1'b1, 0);
		runBatch("backPressure", 3, 1'b0, 5);
		runBatch("full", entryCount, 1'b1, 0);
		testSimultaneous();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: compile.f
src/reorderPkg.sv
src/ringPointerIf.sv
src/unitReportIf.sv
src/ringBufferControl.sv
src/completionCapture.sv
src/reorderTable.sv
src/scalarReorderBuffer.sv
bench/reorderBench.sv

// File: run.sh
#!/usr/bin/env bash
# Build the reorder buffer testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module reorderBench -f compile.f -o reorderSim &&
./obj_dir/reorderSim ||
{ echo "Reorder buffer simulation did not pass"; exit 1; }
